// ==== logic/sa_pkg.sv ====
/*
  systolic matmul shared definitions
  operand and accumulator widths, packed vectors, controller states
*/
`default_nettype none

package sa_pkg;

    // signed 8-bit operands
    localparam int DATA_W = 8;
    // 16 products of extreme operands still fit
    localparam int ACC_W = 20;
    // upper bound on the array edge
    localparam int SA_N_MAX = 8;

    typedef logic signed [DATA_W-1:0] act_t;
    typedef logic signed [ACC_W-1:0] psum_t;

    // one byte per lane with lane 0 in the low byte
    typedef logic [SA_N_MAX*DATA_W-1:0] vec_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FEED,
        ST_DRAIN,
        ST_COLLECT
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/sa_fifo.sv ====
/*
  synchronous valid/ready FIFO
  circular buffer with occupancy count, payload type set per instance
*/
`timescale 1ns/1ps
`default_nettype none

module sa_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire           s_clk,
    input  wire           s_rst,
    input  wire           i_valid,
    input  wire payload_t i_data,
    output logic          o_ready,
    output logic          o_valid,
    output payload_t      o_data,
    input  wire           i_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign o_ready = (count != CNT_W'(DEPTH));
    assign o_valid = (count != '0);
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge s_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/act_ram.sv ====
/*
  activation memory, one column of A per word
  registered address then registered data, two-cycle read latency
*/
`timescale 1ns/1ps
`default_nettype none

module act_ram
    import sa_pkg::*;
#(
    parameter int N      = 4,
    parameter int DEPTH  = 8,
    parameter int ADDR_W = 3
) (
    input  wire              s_clk,
    input  wire              i_we,
    input  wire [ADDR_W-1:0] i_wr_addr,
    input  wire vec_t        i_wr_data,
    input  wire              i_rd_en,
    input  wire [ADDR_W-1:0] i_rd_addr,
    output vec_t             o_rd_data
);

    // only the low N lanes carry data
    localparam vec_t LANE_MASK = vec_t'({(N*DATA_W){1'b1}});

    vec_t              mem [DEPTH];
    logic [ADDR_W-1:0] rd_addr_q;

    always_ff @(posedge s_clk) begin
        if (i_we) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        if (i_rd_en) begin
            rd_addr_q <= i_rd_addr;
        end
        // second stage of the read
        o_rd_data <= mem[rd_addr_q] & LANE_MASK;
    end

endmodule

`default_nettype wire

// ==== logic/sa_pe.sv ====
/*
  systolic processing element
  signed multiply-accumulate, operands forwarded right and down
*/
`timescale 1ns/1ps
`default_nettype none

module sa_pe
    import sa_pkg::*;
(
    input  wire        s_clk,
    input  wire        s_rst,
    input  wire        i_clear,
    input  wire        i_valid,
    input  wire act_t  i_a,
    input  wire act_t  i_b,
    output logic       o_valid,
    output act_t       o_a,
    output act_t       o_b,
    output psum_t      o_acc
);

    psum_t prod;

    // sign-extended to accumulator width
    assign prod = i_a * i_b;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_valid <= 1'b0;
            o_acc   <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_clear) begin
                o_acc <= '0;
            end else if (i_valid) begin
                o_acc <= o_acc + prod;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        o_a <= i_a;
        o_b <= i_b;
    end

endmodule

`default_nettype wire

// ==== logic/sa_array.sv ====
/*
  N x N output-stationary systolic array
  skews the edge operands, runs the cell grid, muxes one accumulator out
*/
`timescale 1ns/1ps
`default_nettype none

module sa_array
    import sa_pkg::*;
#(
    parameter int N = 4,
    localparam int COL_W = (N > 1) ? $clog2(N) : 1
) (
    input  wire             s_clk,
    input  wire             s_rst,
    input  wire             i_clear,
    input  wire             i_feed_valid,
    input  wire vec_t       i_a_vec,
    input  wire vec_t       i_b_vec,
    input  wire [N-1:0]     i_row_grant,
    input  wire [COL_W-1:0] i_col_sel,
    output psum_t           o_psum
);

    // horizontal and vertical operand links with one extra slot at the far edge
    act_t  a_h [N][N+1];
    logic  v_h [N][N+1];
    act_t  b_v [N+1][N];
    psum_t acc [N][N];

    // triangular skew chains where lane i uses stages 0 .. i-1
    act_t  a_sk [N][N];
    act_t  b_sk [N][N];
    logic  v_sk [N][N];

    always_ff @(posedge s_clk) begin
        for (int i = 1; i < N; i++) begin
            a_sk[i][0] <= act_t'(i_a_vec[i*DATA_W +: DATA_W]);
            b_sk[i][0] <= act_t'(i_b_vec[i*DATA_W +: DATA_W]);
            for (int d = 1; d < i; d++) begin
                a_sk[i][d] <= a_sk[i][d-1];
                b_sk[i][d] <= b_sk[i][d-1];
            end
        end
    end

    // valid follows the row operands
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            for (int i = 0; i < N; i++) begin
                for (int d = 0; d < N; d++) begin
                    v_sk[i][d] <= 1'b0;
                end
            end
        end else begin
            for (int i = 1; i < N; i++) begin
                v_sk[i][0] <= i_feed_valid;
                for (int d = 1; d < i; d++) begin
                    v_sk[i][d] <= v_sk[i][d-1];
                end
            end
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_edge
        if (i == 0) begin : g_direct
            assign a_h[0][0] = act_t'(i_a_vec[DATA_W-1:0]);
            assign v_h[0][0] = i_feed_valid;
            assign b_v[0][0] = act_t'(i_b_vec[DATA_W-1:0]);
        end else begin : g_skewed
            assign a_h[i][0] = a_sk[i][i-1];
            assign v_h[i][0] = v_sk[i][i-1];
            assign b_v[0][i] = b_sk[i][i-1];
        end
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            sa_pe u_pe (
                .s_clk   (s_clk),
                .s_rst   (s_rst),
                .i_clear (i_clear),
                .i_valid (v_h[r][c]),
                .i_a     (a_h[r][c]),
                .i_b     (b_v[r][c]),
                .o_valid (v_h[r][c+1]),
                .o_a     (a_h[r][c+1]),
                .o_b     (b_v[r+1][c]),
                .o_acc   (acc[r][c])
            );
        end
    end

    // accumulator of the granted row and selected column
    always_comb begin
        o_psum = '0;
        for (int r = 0; r < N; r++) begin
            if (i_row_grant[r]) begin
                o_psum = acc[r][i_col_sel];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sa_ctrl.sv ====
/*
  systolic job controller
  issues RAM reads and weight pops, aligns them for the array,
  waits out the skew, then moves the N x N sums into the result FIFO
*/
`timescale 1ns/1ps
`default_nettype none

module sa_ctrl
    import sa_pkg::*;
#(
    parameter int N      = 4,
    parameter int K      = 8,
    parameter int ADDR_W = 3,
    localparam int COL_W = (N > 1) ? $clog2(N) : 1
) (
    input  wire              s_clk,
    input  wire              s_rst,
    input  wire              i_start,
    output logic             o_busy,
    input  wire              i_w_valid,
    input  wire vec_t        i_w_data,
    output logic             o_w_pop,
    output logic             o_rd_en,
    output logic [ADDR_W-1:0] o_rd_addr,
    output logic             o_feed_valid,
    output vec_t             o_b_vec,
    output logic             o_clear,
    output logic [N-1:0]     o_row_grant,
    output logic [COL_W-1:0] o_col_sel,
    input  wire psum_t       i_psum,
    output logic             o_res_push,
    output psum_t            o_res_data,
    input  wire              i_res_ready
);

    // RAM latency plus the skew and pipeline of the grid
    localparam int DRAIN_CYC = 2 + 3 * N - 2;
    localparam int DRN_W     = $clog2(DRAIN_CYC + 1);
    localparam int RES_W     = $clog2(N * N + 1);

    ctrl_state_t       state;
    logic [ADDR_W-1:0] k_cnt;
    logic [DRN_W-1:0]  drn_cnt;
    logic [RES_W-1:0]  res_cnt;
    logic              beat;
    logic              push;
    logic              last_col;
    vec_t              w_d1;
    vec_t              w_d2;
    logic              v_d1;
    logic              v_d2;

    // a beat goes out whenever a weight is waiting
    assign beat     = (state == ST_FEED) && i_w_valid;
    assign push     = (state == ST_COLLECT) && i_res_ready;
    assign last_col = (o_col_sel == COL_W'(N - 1));

    assign o_busy       = (state != ST_IDLE);
    assign o_w_pop      = beat;
    assign o_rd_en      = beat;
    assign o_rd_addr    = k_cnt;
    assign o_b_vec      = w_d2;
    assign o_feed_valid = v_d2;
    assign o_res_push   = push;
    assign o_res_data   = i_psum;

    // weight word rides two stages to meet the RAM data
    always_ff @(posedge s_clk) begin
        w_d1 <= i_w_data;
        w_d2 <= w_d1;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            v_d1 <= 1'b0;
            v_d2 <= 1'b0;
        end else begin
            v_d1 <= beat;
            v_d2 <= v_d1;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state       <= ST_IDLE;
            k_cnt       <= '0;
            drn_cnt     <= '0;
            res_cnt     <= '0;
            o_clear     <= 1'b0;
            o_row_grant <= '0;
            o_col_sel   <= '0;
        end else begin
            o_clear <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state   <= ST_FEED;
                        o_clear <= 1'b1;
                        k_cnt   <= '0;
                    end
                end
                ST_FEED: begin
                    if (beat) begin
                        k_cnt <= k_cnt + 1'b1;
                        if (k_cnt == ADDR_W'(K - 1)) begin
                            state   <= ST_DRAIN;
                            drn_cnt <= '0;
                        end
                    end
                end
                ST_DRAIN: begin
                    drn_cnt <= drn_cnt + 1'b1;
                    if (drn_cnt == DRN_W'(DRAIN_CYC - 1)) begin
                        state       <= ST_COLLECT;
                        o_row_grant <= N'(1);
                        o_col_sel   <= '0;
                        res_cnt     <= '0;
                    end
                end
                ST_COLLECT: begin
                    // index holds while the result FIFO is full
                    if (push) begin
                        res_cnt <= res_cnt + 1'b1;
                        if (last_col) begin
                            o_col_sel   <= '0;
                            o_row_grant <= {o_row_grant[N-2:0], o_row_grant[N-1]};
                        end else begin
                            o_col_sel <= o_col_sel + 1'b1;
                        end
                        if (res_cnt == RES_W'(N * N - 1)) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/sa_top.sv ====
/*
  systolic matrix multiplier top level
  activation RAM, weight and result FIFOs, controller and array
*/
`timescale 1ns/1ps
`default_nettype none

module sa_top
    import sa_pkg::*;
#(
    parameter int N      = 4,
    parameter int K      = 8,
    parameter int ADDR_W = 3
) (
    input  wire              s_clk,
    input  wire              s_rst,
    input  wire              i_act_we,
    input  wire [ADDR_W-1:0] i_act_addr,
    input  wire vec_t        i_act_data,
    input  wire              i_w_valid,
    output logic             o_w_ready,
    input  wire vec_t        i_w_data,
    input  wire              i_start,
    output logic             o_busy,
    output logic             o_res_valid,
    input  wire              i_res_ready,
    output psum_t            o_res_data
);

    localparam int COL_W   = (N > 1) ? $clog2(N) : 1;
    localparam int W_DEPTH = K;
    localparam int R_DEPTH = 4;

    logic              wf_valid;
    vec_t              wf_data;
    logic              w_pop;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    vec_t              a_vec;
    vec_t              b_vec;
    logic              feed_valid;
    logic              clear;
    logic [N-1:0]      row_grant;
    logic [COL_W-1:0]  col_sel;
    psum_t             psum;
    logic              res_push;
    psum_t             res_data;
    logic              rf_ready;

    act_ram #(.N(N), .DEPTH(2 ** ADDR_W), .ADDR_W(ADDR_W)) u_act_ram (
        .s_clk     (s_clk),
        .i_we      (i_act_we),
        .i_wr_addr (i_act_addr),
        .i_wr_data (i_act_data),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (a_vec)
    );

    sa_fifo #(.payload_t(vec_t), .DEPTH(W_DEPTH)) u_w_fifo (
        .s_clk   (s_clk),
        .s_rst   (s_rst),
        .i_valid (i_w_valid),
        .i_data  (i_w_data),
        .o_ready (o_w_ready),
        .o_valid (wf_valid),
        .o_data  (wf_data),
        .i_ready (w_pop)
    );

    sa_ctrl #(.N(N), .K(K), .ADDR_W(ADDR_W)) u_ctrl (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_start      (i_start),
        .o_busy       (o_busy),
        .i_w_valid    (wf_valid),
        .i_w_data     (wf_data),
        .o_w_pop      (w_pop),
        .o_rd_en      (rd_en),
        .o_rd_addr    (rd_addr),
        .o_feed_valid (feed_valid),
        .o_b_vec      (b_vec),
        .o_clear      (clear),
        .o_row_grant  (row_grant),
        .o_col_sel    (col_sel),
        .i_psum       (psum),
        .o_res_push   (res_push),
        .o_res_data   (res_data),
        .i_res_ready  (rf_ready)
    );

    sa_array #(.N(N)) u_array (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_clear      (clear),
        .i_feed_valid (feed_valid),
        .i_a_vec      (a_vec),
        .i_b_vec      (b_vec),
        .i_row_grant  (row_grant),
        .i_col_sel    (col_sel),
        .o_psum       (psum)
    );

    sa_fifo #(.payload_t(psum_t), .DEPTH(R_DEPTH)) u_res_fifo (
        .s_clk   (s_clk),
        .s_rst   (s_rst),
        .i_valid (res_push),
        .i_data  (res_data),
        .o_ready (rf_ready),
        .o_valid (o_res_valid),
        .o_data  (o_res_data),
        .i_ready (i_res_ready)
    );

endmodule

`default_nettype wire

// ==== verif/tb_sa_top.sv ====
/*
  testbench for the systolic matrix multiplier
  random and extreme jobs, weight gaps and result back-pressure,
  every result checked against a software matrix product
*/
`timescale 1ns/1ps
`default_nettype none

module tb_sa_top
    import sa_pkg::*;
();

    localparam int N      = 4;
    localparam int K      = 8;
    localparam int ADDR_W = 3;
    // one job covers feed, skew drain, collect under back-pressure and slack
    localparam int JOB_CYC    = K + 3 * N + N * N * 4 + 50;
    // six jobs plus RAM loads and reset with margin
    localparam int MAX_CYCLES = 1000;

    logic              s_clk;
    logic              s_rst;
    logic              i_act_we;
    logic [ADDR_W-1:0] i_act_addr;
    vec_t              i_act_data;
    logic              i_w_valid;
    logic              o_w_ready;
    vec_t              i_w_data;
    logic              i_start;
    logic              o_busy;
    logic              o_res_valid;
    logic              i_res_ready;
    psum_t             o_res_data;

    // operand copies and the expected product
    logic signed [7:0] a_m [N][K];
    logic signed [7:0] b_m [K][N];
    int                c_ref [N][N];

    psum_t  exp_q [$];
    psum_t  exp_val;
    int     rx_count = 0;
    int     rx_target;
    int     res_err = 0;
    int     state_err;
    int     flow_err;
    int     cycle_cnt = 0;
    integer seed;

    sa_top #(.N(N), .K(K), .ADDR_W(ADDR_W)) i_dut (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_act_we    (i_act_we),
        .i_act_addr  (i_act_addr),
        .i_act_data  (i_act_data),
        .i_w_valid   (i_w_valid),
        .o_w_ready   (o_w_ready),
        .i_w_data    (i_w_data),
        .i_start     (i_start),
        .o_busy      (o_busy),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready),
        .o_res_data  (o_res_data)
    );

    always #5 s_clk = ~s_clk;

    // C[i][j] = sum over k of A[i][k] * B[k][j]
    function automatic void ref_matmul();
        int sum;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = 0;
                for (int k = 0; k < K; k++) begin
                    sum += int'(a_m[i][k]) * int'(b_m[k][j]);
                end
                c_ref[i][j] = sum;
            end
        end
    endfunction

    // column k of A with row 0 in the low byte
    function automatic vec_t a_column(input int k);
        vec_t w;
        w = '0;
        for (int i = 0; i < N; i++) begin
            w[i*8 +: 8] = a_m[i][k];
        end
        return w;
    endfunction

    // row k of B with column 0 in the low byte
    function automatic vec_t b_row(input int k);
        vec_t w;
        w = '0;
        for (int j = 0; j < N; j++) begin
            w[j*8 +: 8] = b_m[k][j];
        end
        return w;
    endfunction

    // mode 0 random, 1 both -128, 2 A -128 and B 127
    task automatic fill_operands(input int mode);
        int rnd;
        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < K; k++) begin
                rnd = $random(seed);
                a_m[i][k] = (mode == 0) ? rnd[7:0] : 8'h80;
            end
        end
        for (int k = 0; k < K; k++) begin
            for (int j = 0; j < N; j++) begin
                rnd = $random(seed);
                if (mode == 0) begin
                    b_m[k][j] = rnd[7:0];
                end else if (mode == 1) begin
                    b_m[k][j] = 8'h80;
                end else begin
                    b_m[k][j] = 8'h7f;
                end
            end
        end
    endtask

    task automatic expect_bit(input string name, input logic want, input logic got);
        assert (got === want) else begin
            $display("ERR t=%0t %s expected %0b actual %0b", $time, name, want, got);
            state_err++;
        end
    endtask

    task automatic load_ram();
        for (int k = 0; k < K; k++) begin
            @(negedge s_clk);
            i_act_we   = 1'b1;
            i_act_addr = ADDR_W'(k);
            i_act_data = a_column(k);
        end
        @(negedge s_clk);
        i_act_we = 1'b0;
    endtask

    task automatic run_job(input int job, input int mode, input bit gaps, input bit bp);
        int k_sent;
        int cyc;
        int rnd;
        bit w_taken;
        fill_operands(mode);
        ref_matmul();
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                exp_q.push_back(psum_t'(c_ref[i][j]));
            end
        end
        rx_target += N * N;
        load_ram();
        expect_bit("o_busy", 1'b0, o_busy);
        i_start = 1'b1;
        @(negedge s_clk);
        i_start = 1'b0;
        expect_bit("o_busy", 1'b1, o_busy);
        k_sent  = 0;
        cyc     = 0;
        w_taken = 1'b0;
        while ((o_busy || rx_count < rx_target) && cyc < JOB_CYC) begin
            // a new weight word only once the last one was taken
            if (!i_w_valid || w_taken) begin
                rnd = $random(seed);
                if (k_sent < K && !(gaps && rnd[0])) begin
                    i_w_valid = 1'b1;
                    i_w_data  = b_row(k_sent);
                end else begin
                    i_w_valid = 1'b0;
                end
            end
            if (bp) begin
                rnd         = $random(seed);
                i_res_ready = rnd[0];
            end else begin
                i_res_ready = 1'b1;
            end
            // transfer on the coming rising edge
            w_taken = i_w_valid && o_w_ready;
            if (w_taken) begin
                k_sent++;
            end
            @(negedge s_clk);
            cyc++;
        end
        i_w_valid   = 1'b0;
        i_res_ready = 1'b1;
        assert (!o_busy) else begin
            $display("job %0d: o_busy still high after %0d cycles", job, cyc);
            flow_err++;
        end
        assert (rx_count == rx_target) else begin
            $display("job %0d: %0d results received in total, %0d expected",
                     job, rx_count, rx_target);
            flow_err++;
        end
        assert (k_sent == K) else begin
            $display("job %0d: only %0d of %0d weight words accepted", job, k_sent, K);
            flow_err++;
        end
    endtask

    // result monitor in row-major order
    always @(posedge s_clk) begin
        if (!s_rst && o_res_valid && i_res_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("t=%0t: result %0d arrived with no job waiting for it",
                         $time, o_res_data);
                res_err++;
            end
            if (exp_q.size() > 0) begin
                exp_val = exp_q.pop_front();
                assert (o_res_data == exp_val) else begin
                    $display("ERR t=%0t o_res_data expected %0d actual %0d",
                             $time, exp_val, o_res_data);
                    res_err++;
                end
            end
            rx_count++;
        end
    end

    // watchdog
    always @(posedge s_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("errors: results %0d, state %0d, flow %0d", res_err, state_err, flow_err);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        seed        = 33073;
        s_clk       = 1'b0;
        s_rst       = 1'b1;
        i_act_we    = 1'b0;
        i_act_addr  = '0;
        i_act_data  = '0;
        i_w_valid   = 1'b0;
        i_w_data    = '0;
        i_start     = 1'b0;
        i_res_ready = 1'b1;
        rx_target   = 0;
        state_err   = 0;
        flow_err    = 0;
        repeat (5) @(posedge s_clk);
        @(negedge s_clk);
        s_rst = 1'b0;

        expect_bit("o_busy", 1'b0, o_busy);
        expect_bit("o_res_valid", 1'b0, o_res_valid);
        expect_bit("o_w_ready", 1'b1, o_w_ready);

        // single job, then a second one straight after
        run_job(1, 0, 1'b0, 1'b0);
        run_job(2, 0, 1'b0, 1'b0);
        // weight gaps, then result back-pressure
        run_job(3, 0, 1'b1, 1'b0);
        run_job(4, 0, 1'b0, 1'b1);
        // signed extremes
        run_job(5, 1, 1'b0, 1'b0);
        run_job(6, 2, 1'b0, 1'b0);

        // catch any stray extra result
        repeat (10) @(negedge s_clk);
        assert (rx_count == rx_target) else begin
            $display("%0d results received after the last job, %0d expected",
                     rx_count, rx_target);
            flow_err++;
        end

        $display("errors: results %0d, state %0d, flow %0d", res_err, state_err, flow_err);
        if (res_err + state_err + flow_err == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/sa_pkg.sv
logic/sa_fifo.sv
logic/act_ram.sv
logic/sa_pe.sv
logic/sa_array.sv
logic/sa_ctrl.sv
logic/sa_top.sv
verif/tb_sa_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_sa_top -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    exit 1
fi
exit 0
